//--- source/pipe_cpu_cfg.svh
// Width configuration for the five-stage load/store pipeline core
// Shared by the package and every RTL block that sizes a port

`ifndef PIPE_CPU_CFG_SVH
`define PIPE_CPU_CFG_SVH

// ========================================
// Instruction side
// ========================================

// Instruction word from the instruction memory
`define INSTR_WIDTH 32
// Instruction address, 512 words
`define PC_WIDTH 9

// ========================================
// Data side
// ========================================

// Register and data memory word
`define DATA_WIDTH 64
// Register index, eight registers
`define REG_ADDR_WIDTH 3
`define NUM_REGS 8
// Data memory address, low byte of the address register
`define DMEM_ADDR_WIDTH 8

`endif

//--- source/pipe_cpu_pkg.sv
// Shared types of the load/store pipeline core
// Instruction layout, stage control, operand pair and debug selector

`include "pipe_cpu_cfg.svh"

package pipe_cpu_pkg;

    // Instruction word, flags in the top two bits
    typedef struct packed {
        logic                         mem_write;
        logic                         reg_write;
        // Store data register
        logic [`REG_ADDR_WIDTH-1:0]   src_data;
        // Address register
        logic [`REG_ADDR_WIDTH-1:0]   src_addr;
        logic [`REG_ADDR_WIDTH-1:0]   dest;
        logic [`INSTR_WIDTH-3*`REG_ADDR_WIDTH-3:0] unused;
    } instr_t;

    // Control bits carried down the pipe
    typedef struct packed {
        logic                         reg_write;
        logic                         mem_write;
        logic [`REG_ADDR_WIDTH-1:0]   dest;
    } ctrl_t;

    // Register read pair, address word first
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]       addr_word;
        logic [`DATA_WIDTH-1:0]       data_word;
    } operand_t;

    // ========================================
    // Debug selector
    // ========================================

    // Mode 0 picks an internal signal by index
    typedef struct packed {
        logic                         mode;
        logic [3:0]                   index;
    } dbg_sys_t;

    // Mode 1 picks a register
    typedef struct packed {
        logic                         mode;
        logic                         pad;
        logic [`REG_ADDR_WIDTH-1:0]   addr;
    } dbg_reg_t;

    typedef union packed {
        dbg_sys_t                     sys_view;
        dbg_reg_t                     reg_view;
    } dbg_sel_u;

    // System view indices
    localparam logic [3:0] DBG_SYS_PC        = 4'd0;
    localparam logic [3:0] DBG_SYS_INSTR     = 4'd1;
    localparam logic [3:0] DBG_SYS_RD_A      = 4'd2;
    localparam logic [3:0] DBG_SYS_RD_B      = 4'd3;
    localparam logic [3:0] DBG_SYS_EX_ADDR   = 4'd4;
    localparam logic [3:0] DBG_SYS_EX_DATA   = 4'd5;
    localparam logic [3:0] DBG_SYS_MEM_RDATA = 4'd6;
    localparam logic [3:0] DBG_SYS_CTRL      = 4'd7;
    localparam logic [3:0] DBG_SYS_ID_DEST   = 4'd8;
    localparam logic [3:0] DBG_SYS_WB_DEST   = 4'd9;

endpackage

//--- source/fetch_unit.sv
// Fetch stage of the load/store pipeline core
// Saturating program counter and the fetch-to-decode instruction register

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic [`INSTR_WIDTH-1:0] instr_i,
    output logic [`PC_WIDTH-1:0]    pc_o,
    output pipe_cpu_pkg::instr_t    instr_id_o,
    output logic                    done_o
);
    import pipe_cpu_pkg::*;

    // Last address of the program
    localparam logic [`PC_WIDTH-1:0] PC_LAST = {`PC_WIDTH{1'b1}};

    logic [`PC_WIDTH-1:0] pc_q;
    instr_t               instr_id_q;
    logic                 at_last;

    assign at_last = (pc_q == PC_LAST);

    // PC steps once per cycle and parks at all ones
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (!at_last) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    // IF/ID register, a cleared word decodes as no operation
    always_ff @(posedge clk) begin
        if (rst_i) begin
            instr_id_q <= '0;
        end else begin
            instr_id_q <= instr_t'(instr_i);
        end
    end

    assign pc_o       = pc_q;
    assign instr_id_o = instr_id_q;
    // Done holds as long as the PC sits at the end
    assign done_o     = at_last;

endmodule

//--- source/pipe_ctrl.sv
// Pipeline controller of the load/store core
// Decodes the write flags and destination, then carries them down
// the execute, memory and write-back registers

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module pipe_ctrl (
    input  logic                 clk,
    input  logic                 rst_i,
    input  pipe_cpu_pkg::instr_t instr_id_i,
    output pipe_cpu_pkg::ctrl_t  ctrl_id_o,
    output pipe_cpu_pkg::ctrl_t  ctrl_mem_o,
    output pipe_cpu_pkg::ctrl_t  ctrl_wb_o
);
    import pipe_cpu_pkg::*;

    ctrl_t ctrl_id;
    ctrl_t ctrl_ex_q;
    ctrl_t ctrl_mem_q;
    ctrl_t ctrl_wb_q;

    // ========================================
    // Decode
    // ========================================

    // Only the flags and the destination matter here
    // Source fields go straight to the register file
    always_comb begin
        ctrl_id.reg_write = instr_id_i.reg_write;
        ctrl_id.mem_write = instr_id_i.mem_write;
        ctrl_id.dest      = instr_id_i.dest;
    end

    // ========================================
    // Stage registers
    // ========================================

    // ID/EX
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_ex_q <= '0;
        end else begin
            ctrl_ex_q <= ctrl_id;
        end
    end

    // EX/MEM, mem_write here is the data memory write enable
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_mem_q <= '0;
        end else begin
            ctrl_mem_q <= ctrl_ex_q;
        end
    end

    // MEM/WB
    // Lines up with the read data coming back from the data memory
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_wb_q <= '0;
        end else begin
            ctrl_wb_q <= ctrl_mem_q;
        end
    end

    assign ctrl_id_o  = ctrl_id;
    assign ctrl_mem_o = ctrl_mem_q;
    // Register file write port is driven from here
    assign ctrl_wb_o  = ctrl_wb_q;

endmodule

//--- source/operand_path.sv
// Operand path of the load/store core
// Moves the two register read words through execute and memory
// and presents them as data memory address and write data

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module operand_path (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic [`DATA_WIDTH-1:0]      rd_a_i,
    input  logic [`DATA_WIDTH-1:0]      rd_b_i,
    output pipe_cpu_pkg::operand_t      ops_ex_o,
    output pipe_cpu_pkg::operand_t      ops_mem_o,
    output logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_o,
    output logic [`DATA_WIDTH-1:0]      dmem_wdata_o
);
    import pipe_cpu_pkg::*;

    operand_t ops_ex_q;
    operand_t ops_mem_q;

    // ID/EX, port A holds the address and port B the store data
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ops_ex_q <= '0;
        end else begin
            ops_ex_q.addr_word <= rd_a_i;
            ops_ex_q.data_word <= rd_b_i;
        end
    end

    // EX/MEM
    // No ALU, so the execute stage passes the pair unchanged
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ops_mem_q <= '0;
        end else begin
            ops_mem_q <= ops_ex_q;
        end
    end

    assign ops_ex_o     = ops_ex_q;
    assign ops_mem_o    = ops_mem_q;

    // Data memory only sees the low byte of the address word
    assign dmem_addr_o  = ops_mem_q.addr_word[`DMEM_ADDR_WIDTH-1:0];
    assign dmem_wdata_o = ops_mem_q.data_word;

endmodule

//--- source/reg_file.sv
// Register file of the load/store core
// Eight 64-bit registers, two read ports, one write port, one debug port

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst_i,
    // Decode read ports
    input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_a_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_b_i,
    output logic [`DATA_WIDTH-1:0]     rd_a_o,
    output logic [`DATA_WIDTH-1:0]     rd_b_o,
    // Write-back port
    input  logic                       wr_en_i,
    input  logic [`REG_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [`DATA_WIDTH-1:0]     wr_data_i,
    // Debug read port
    input  logic [`REG_ADDR_WIDTH-1:0] dbg_addr_i,
    output logic [`DATA_WIDTH-1:0]     dbg_data_o
);

    logic [`DATA_WIDTH-1:0] regs_q [`NUM_REGS];

    // Cleared on reset so results are repeatable
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // ========================================
    // Read ports
    // ========================================

    // No bypass of the write port
    // A value written this cycle shows up on the next one
    assign rd_a_o     = regs_q[rd_addr_a_i];
    assign rd_b_o     = regs_q[rd_addr_b_i];
    assign dbg_data_o = regs_q[dbg_addr_i];

endmodule

//--- source/debug_view.sv
// Debug view of the load/store core
// Decodes the debug selector and returns an internal value or a register

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module debug_view (
    input  pipe_cpu_pkg::dbg_sel_u   sel_i,
    input  logic [`PC_WIDTH-1:0]     pc_i,
    input  pipe_cpu_pkg::instr_t     instr_id_i,
    input  logic [`DATA_WIDTH-1:0]   rd_a_i,
    input  logic [`DATA_WIDTH-1:0]   rd_b_i,
    input  pipe_cpu_pkg::operand_t   ops_ex_i,
    input  logic [`DATA_WIDTH-1:0]   dmem_rdata_i,
    input  pipe_cpu_pkg::ctrl_t      ctrl_id_i,
    input  pipe_cpu_pkg::ctrl_t      ctrl_mem_i,
    input  pipe_cpu_pkg::ctrl_t      ctrl_wb_i,
    input  logic [`DATA_WIDTH-1:0]   reg_data_i,
    output logic [`DATA_WIDTH-1:0]   data_o
);
    import pipe_cpu_pkg::*;

    // Zero fill for the narrow views
    localparam int PC_PAD    = `DATA_WIDTH - `PC_WIDTH;
    localparam int INSTR_PAD = `DATA_WIDTH - `INSTR_WIDTH;
    localparam int DEST_PAD  = `DATA_WIDTH - `REG_ADDR_WIDTH;

    logic [3:0] ctrl_vec;

    // Bit 3 down to bit 0
    assign ctrl_vec = {ctrl_wb_i.reg_write, ctrl_mem_i.mem_write,
                       ctrl_id_i.mem_write, ctrl_id_i.reg_write};

    // Purely combinational from the selector and current state
    always_comb begin
        if (sel_i.reg_view.mode) begin
            // Register view, address already routed to the register file
            data_o = reg_data_i;
        end else begin
            case (sel_i.sys_view.index)
                DBG_SYS_PC:        data_o = {{PC_PAD{1'b0}}, pc_i};
                DBG_SYS_INSTR:     data_o = {{INSTR_PAD{1'b0}}, instr_id_i};
                DBG_SYS_RD_A:      data_o = rd_a_i;
                DBG_SYS_RD_B:      data_o = rd_b_i;
                DBG_SYS_EX_ADDR:   data_o = ops_ex_i.addr_word;
                DBG_SYS_EX_DATA:   data_o = ops_ex_i.data_word;
                DBG_SYS_MEM_RDATA: data_o = dmem_rdata_i;
                DBG_SYS_CTRL:      data_o = {{(`DATA_WIDTH-4){1'b0}}, ctrl_vec};
                DBG_SYS_ID_DEST:   data_o = {{DEST_PAD{1'b0}}, ctrl_id_i.dest};
                DBG_SYS_WB_DEST:   data_o = {{DEST_PAD{1'b0}}, ctrl_wb_i.dest};
                // Indices 10 to 15 are not mapped
                default:           data_o = {`DATA_WIDTH{1'b1}};
            endcase
        end
    end

endmodule

//--- source/pipe_cpu.sv
// Top level of the five-stage load/store pipeline core
// Connects the controller and datapath blocks to the memory and debug ports

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module pipe_cpu (
    input  logic                        clk,
    input  logic                        rst_i,
    // Instruction memory with combinational read
    output logic [`PC_WIDTH-1:0]        i_mem_addr_o,
    input  logic [`INSTR_WIDTH-1:0]     i_mem_data_i,
    // Data memory returns read data one cycle after the address
    output logic [`DMEM_ADDR_WIDTH-1:0] d_mem_addr_o,
    output logic [`DATA_WIDTH-1:0]      d_mem_data_o,
    output logic                        d_mem_wen_o,
    input  logic [`DATA_WIDTH-1:0]      d_mem_data_i,
    output logic                        cpu_done_o,
    // Multiplexed debug port
    input  pipe_cpu_pkg::dbg_sel_u      debug_sel_i,
    output logic [`DATA_WIDTH-1:0]      debug_data_o
);
    import pipe_cpu_pkg::*;

    instr_t                 instr_id;
    ctrl_t                  ctrl_id;
    ctrl_t                  ctrl_mem;
    ctrl_t                  ctrl_wb;
    operand_t               ops_ex;
    logic [`DATA_WIDTH-1:0] rd_a;
    logic [`DATA_WIDTH-1:0] rd_b;
    logic [`DATA_WIDTH-1:0] dbg_reg_data;

    // ========================================
    // Fetch and control
    // ========================================

    fetch_unit u_fetch (
        .clk        (clk),
        .rst_i      (rst_i),
        .instr_i    (i_mem_data_i),
        .pc_o       (i_mem_addr_o),
        .instr_id_o (instr_id),
        .done_o     (cpu_done_o)
    );

    pipe_ctrl u_ctrl (
        .clk        (clk),
        .rst_i      (rst_i),
        .instr_id_i (instr_id),
        .ctrl_id_o  (ctrl_id),
        .ctrl_mem_o (ctrl_mem),
        .ctrl_wb_o  (ctrl_wb)
    );

    // ========================================
    // Datapath
    // ========================================

    // Loads write back the data memory read word
    reg_file u_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_addr_a_i (instr_id.src_addr),
        .rd_addr_b_i (instr_id.src_data),
        .rd_a_o      (rd_a),
        .rd_b_o      (rd_b),
        .wr_en_i     (ctrl_wb.reg_write),
        .wr_addr_i   (ctrl_wb.dest),
        .wr_data_i   (d_mem_data_i),
        .dbg_addr_i  (debug_sel_i.reg_view.addr),
        .dbg_data_o  (dbg_reg_data)
    );

    operand_path u_ops (
        .clk          (clk),
        .rst_i        (rst_i),
        .rd_a_i       (rd_a),
        .rd_b_i       (rd_b),
        .ops_ex_o     (ops_ex),
        .ops_mem_o    (),
        .dmem_addr_o  (d_mem_addr_o),
        .dmem_wdata_o (d_mem_data_o)
    );

    // Memory-stage store flag
    assign d_mem_wen_o = ctrl_mem.mem_write;

    debug_view u_debug (
        .sel_i        (debug_sel_i),
        .pc_i         (i_mem_addr_o),
        .instr_id_i   (instr_id),
        .rd_a_i       (rd_a),
        .rd_b_i       (rd_b),
        .ops_ex_i     (ops_ex),
        .dmem_rdata_i (d_mem_data_i),
        .ctrl_id_i    (ctrl_id),
        .ctrl_mem_i   (ctrl_mem),
        .ctrl_wb_i    (ctrl_wb),
        .reg_data_i   (dbg_reg_data),
        .data_o       (debug_data_o)
    );

endmodule

//--- verification/tb_pipe_cpu.sv
// Testbench for the five-stage load/store pipeline core
// Models both memories, runs a random load/store program against a reference
// model, then sweeps the debug port

`timescale 1ns/100ps
`include "pipe_cpu_cfg.svh"

module tb_pipe_cpu;
    import pipe_cpu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_WORDS    = 1 << `PC_WIDTH;
    localparam int DMEM_WORDS   = 1 << `DMEM_ADDR_WIDTH;
    localparam int PC_LAST      = NUM_WORDS - 1;
    localparam int NUM_INSTR    = 40;
    localparam int SWEEP_CYCLES = 20;
    localparam int WATCHDOG_NS  = (NUM_WORDS + 20) * CLK_PERIOD + SWEEP_CYCLES * CLK_PERIOD;

    logic                        clk = 1'b0;
    logic                        rst_i = 1'b1;
    logic [`PC_WIDTH-1:0]        i_mem_addr;
    logic [`INSTR_WIDTH-1:0]     i_mem_data;
    logic [`DMEM_ADDR_WIDTH-1:0] d_mem_addr;
    logic [`DATA_WIDTH-1:0]      d_mem_wdata;
    logic [`DATA_WIDTH-1:0]      d_mem_rdata;
    logic                        d_mem_wen;
    logic                        cpu_done;
    dbg_sel_u                    debug_sel = '0;
    logic [`DATA_WIDTH-1:0]      debug_data;

    // Memories and the expected results
    logic [`INSTR_WIDTH-1:0]     imem [NUM_WORDS];
    logic [`DATA_WIDTH-1:0]      dmem [DMEM_WORDS];
    logic [`DMEM_ADDR_WIDTH-1:0] rd_addr_q = '0;
    logic [`DMEM_ADDR_WIDTH-1:0] exp_store_addr [$];
    logic [`DATA_WIDTH-1:0]      exp_store_data [$];
    logic [`DATA_WIDTH-1:0]      exp_regs [`NUM_REGS];
    logic [31:0]                 lfsr_state = 32'hb9bee03e;
    int                          cyc = 0;
    int                          store_idx = 0;
    bit                          checking = 1'b0;

    pipe_cpu uut (
        .clk          (clk),
        .rst_i        (rst_i),
        .i_mem_addr_o (i_mem_addr),
        .i_mem_data_i (i_mem_data),
        .d_mem_addr_o (d_mem_addr),
        .d_mem_data_o (d_mem_wdata),
        .d_mem_wen_o  (d_mem_wen),
        .d_mem_data_i (d_mem_rdata),
        .cpu_done_o   (cpu_done),
        .debug_sel_i  (debug_sel),
        .debug_data_o (debug_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Memory models
    // ========================================

    // Instruction memory reads combinationally
    assign i_mem_data = imem[i_mem_addr];

    // Data memory with registered read address and write on wen
    always @(posedge clk) begin
        rd_addr_q <= d_mem_addr;
        if (d_mem_wen) begin
            dmem[d_mem_addr] <= d_mem_wdata;
        end
    end
    assign d_mem_rdata = dmem[rd_addr_q];

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic dbg_sel_u sys_select(input logic [3:0] idx);
        dbg_sel_u s;
        s = '0;
        s.sys_view.index = idx;
        return s;
    endfunction

    function automatic dbg_sel_u reg_select(input logic [`REG_ADDR_WIDTH-1:0] r);
        dbg_sel_u s;
        s = '0;
        s.reg_view.mode = 1'b1;
        s.reg_view.addr = r;
        return s;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic stop_on_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    // Random data words first, then 40 loads or stores
    // Each instruction is padded by four empty words
    task automatic build_memories();
        logic [63:0] v;
        instr_t      w;
        for (int a = 0; a < DMEM_WORDS; a++) begin
            take_bits(`DATA_WIDTH, v);
            dmem[a] = v;
        end
        for (int a = 0; a < NUM_WORDS; a++) begin
            imem[a] = '0;
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            take_bits(1, v);
            w.mem_write = v[0];
            w.reg_write = ~v[0];
            take_bits(3, v);
            w.src_data = v[2:0];
            take_bits(3, v);
            w.src_addr = v[2:0];
            take_bits(3, v);
            w.dest = v[2:0];
            take_bits(21, v);
            w.unused = v[20:0];
            imem[5 * i] = w;
        end
    endtask

    // In-order program model stepping one instruction at a time
    function automatic void run_reference();
        logic [63:0]                 regs [`NUM_REGS];
        logic [63:0]                 mem [DMEM_WORDS];
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        instr_t                      w;
        for (int r = 0; r < `NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            mem[a] = dmem[a];
        end
        for (int pc = 0; pc < NUM_WORDS; pc++) begin
            w = instr_t'(imem[pc]);
            addr = regs[w.src_addr][`DMEM_ADDR_WIDTH-1:0];
            if (w.mem_write) begin
                exp_store_addr.push_back(addr);
                exp_store_data.push_back(regs[w.src_data]);
                mem[addr] = regs[w.src_data];
            end
            if (w.reg_write) begin
                regs[w.dest] = mem[addr];
            end
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            exp_regs[r] = regs[r];
        end
    endfunction

    // ========================================
    // Per-cycle checks at the falling edge
    // ========================================

    always @(negedge clk) begin
        logic [63:0] exp_pc;
        if (checking) begin
            exp_pc = (cyc < PC_LAST) ? cyc : PC_LAST;
            // Nothing reaches the memory stage before cycle 3
            if (cyc < 3) begin
                assert (!d_mem_wen) else report_mismatch("d_mem_wen_o", 0, d_mem_wen);
            end
            assert (cpu_done == (cyc >= PC_LAST))
                else report_mismatch("cpu_done_o", cyc >= PC_LAST, cpu_done);
            assert (i_mem_addr == exp_pc[`PC_WIDTH-1:0])
                else report_mismatch("i_mem_addr_o", exp_pc, i_mem_addr);
            if (debug_sel.sys_view.index == DBG_SYS_PC) begin
                assert (debug_data == exp_pc)
                    else report_mismatch("debug_data_o pc", exp_pc, debug_data);
            end else begin
                assert (debug_data == {32'b0, imem[cyc-1]})
                    else report_mismatch("debug_data_o instr", {32'b0, imem[cyc-1]}, debug_data);
            end
            if (d_mem_wen) begin
                assert (store_idx < exp_store_addr.size())
                    else stop_on_error("more stores on the data port than the program holds");
                assert (d_mem_addr == exp_store_addr[store_idx])
                    else report_mismatch("d_mem_addr_o", exp_store_addr[store_idx], d_mem_addr);
                assert (d_mem_wdata == exp_store_data[store_idx])
                    else report_mismatch("d_mem_data_o", exp_store_data[store_idx], d_mem_wdata);
                store_idx++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before the run finished");
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        int stores_at_done;
        debug_sel = sys_select(DBG_SYS_PC);
        build_memories();
        run_reference();
        repeat (5) @(posedge clk);
        #2;
        rst_i = 1'b0;
        cyc = 0;
        checking = 1'b1;
        // PC view on even cycles and decode word on odd ones
        // Only the PC once done
        while (!cpu_done) begin
            @(posedge clk);
            #2;
            cyc++;
            debug_sel = (cyc % 2 == 0 || cpu_done) ? sys_select(DBG_SYS_PC)
                                                  : sys_select(DBG_SYS_INSTR);
        end
        stores_at_done = store_idx;
        repeat (5) begin
            @(posedge clk);
            #2;
            cyc++;
        end
        checking = 1'b0;
        assert (cpu_done) else report_mismatch("cpu_done_o", 1, cpu_done);
        assert (store_idx == stores_at_done)
            else report_mismatch("store count after done", stores_at_done, store_idx);
        assert (store_idx == exp_store_addr.size())
            else report_mismatch("store count", exp_store_addr.size(), store_idx);
        // Register sweep through the debug port
        for (int r = 0; r < `NUM_REGS; r++) begin
            debug_sel = reg_select(r);
            @(negedge clk);
            assert (debug_data == exp_regs[r])
                else report_mismatch($sformatf("debug_data_o reg %0d", r), exp_regs[r], debug_data);
            @(posedge clk);
            #2;
        end
        // Unmapped system indices
        for (int idx = 10; idx < 16; idx++) begin
            debug_sel = sys_select(idx);
            @(negedge clk);
            assert (debug_data == '1)
                else report_mismatch($sformatf("debug_data_o sys %0d", idx), '1, debug_data);
            @(posedge clk);
            #2;
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- pipe_cpu.f
+incdir+source
source/pipe_cpu_pkg.sv
source/fetch_unit.sv
source/pipe_ctrl.sv
source/operand_path.sv
source/reg_file.sv
source/debug_view.sv
source/pipe_cpu.sv
verification/tb_pipe_cpu.sv
